// File: hdl/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath and pc width
`define ID_XLEN 32

// fixed-length instruction word
`define ID_INST_W 32

// architectural register file
`define ID_REG_ADDR_W 5
`define ID_REG_COUNT 32

`endif

// File: hdl/id_pkg.sv
`default_nettype none

package id_pkg;

    // operation handed to execute
    // link and pc-relative forms reuse the adder
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    // resolved in decode
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BLT  = 4'd3,
        BR_BGE  = 4'd4,
        BR_BLTU = 4'd5,
        BR_BGEU = 4'd6,
        BR_B    = 4'd7,
        BR_BL   = 4'd8,
        BR_JIRL = 4'd9
    } br_kind_e;

endpackage

`default_nettype wire

// File: hdl/fetch_latch.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module fetch_latch (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire                   if_valid,
    input  wire [`ID_XLEN-1:0]    if_pc,
    input  wire [`ID_INST_W-1:0]  if_inst,
    input  wire                   id_allowin,
    input  wire                   br_cancel,
    output logic                  id_valid,
    output logic [`ID_XLEN-1:0]   id_pc,
    output logic [`ID_INST_W-1:0] id_inst
);

    // stage occupancy
    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_cancel) begin
            // wrong-path item from fetch is dropped
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allowin) begin
            id_pc   <= if_pc;
            id_inst <= if_inst;
        end
    end

    // stalled item must not change under execute back-pressure
    pc_hold_on_stall: assert property (@(posedge clk) disable iff (!resetn)
        id_valid && !id_allowin |=> $stable(id_pc));

endmodule

`default_nettype wire

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module inst_decoder (
    input  wire [`ID_INST_W-1:0]     id_inst,
    output logic [`ID_REG_ADDR_W-1:0] rj,
    output logic [`ID_REG_ADDR_W-1:0] rkd,
    output logic [`ID_REG_ADDR_W-1:0] dest,
    output id_pkg::alu_op_e          alu_op,
    output id_pkg::br_kind_e         br_kind,
    output logic [`ID_XLEN-1:0]      imm,
    output logic [`ID_XLEN-1:0]      br_offs,
    output logic                     src1_is_pc,
    output logic                     src2_is_imm,
    output logic                     src2_is_shamt,
    output logic                     gr_we,
    output logic                     ine
);

    import id_pkg::*;

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;

    assign op_31_26 = id_inst[31:26];
    assign op_25_22 = id_inst[25:22];
    assign op_21_20 = id_inst[21:20];
    assign op_19_15 = id_inst[19:15];

    assign rd  = id_inst[4:0];
    assign rj  = id_inst[9:5];
    assign rk  = id_inst[14:10];
    assign i12 = id_inst[21:10];
    assign i20 = id_inst[24:5];
    assign i16 = id_inst[25:10];
    // offs[15:0] sits above offs[25:16] in the encoding
    assign i26 = {id_inst[9:0], id_inst[25:10]};

    // 3R group shares the upper fields
    logic grp_3r;
    logic grp_shi;
    assign grp_3r  = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign grp_shi = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic inst_b, inst_bl, inst_jirl;
    logic cond_br;

    assign inst_add_w  = grp_3r && (op_19_15 == 5'h00);
    assign inst_sub_w  = grp_3r && (op_19_15 == 5'h02);
    assign inst_slt    = grp_3r && (op_19_15 == 5'h04);
    assign inst_sltu   = grp_3r && (op_19_15 == 5'h05);
    assign inst_nor    = grp_3r && (op_19_15 == 5'h08);
    assign inst_and    = grp_3r && (op_19_15 == 5'h09);
    assign inst_or     = grp_3r && (op_19_15 == 5'h0a);
    assign inst_xor    = grp_3r && (op_19_15 == 5'h0b);
    assign inst_sll_w  = grp_3r && (op_19_15 == 5'h0e);
    assign inst_srl_w  = grp_3r && (op_19_15 == 5'h0f);
    assign inst_sra_w  = grp_3r && (op_19_15 == 5'h10);
    assign inst_slli_w = grp_shi && (op_19_15 == 5'h01);
    assign inst_srli_w = grp_shi && (op_19_15 == 5'h09);
    assign inst_srai_w = grp_shi && (op_19_15 == 5'h11);

    assign inst_slti   = (op_31_26 == 6'h00) && (op_25_22 == 4'h8);
    assign inst_sltui  = (op_31_26 == 6'h00) && (op_25_22 == 4'h9);
    assign inst_addi_w = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_andi   = (op_31_26 == 6'h00) && (op_25_22 == 4'hd);
    assign inst_ori    = (op_31_26 == 6'h00) && (op_25_22 == 4'he);
    assign inst_xori   = (op_31_26 == 6'h00) && (op_25_22 == 4'hf);

    assign inst_lu12i_w   = (op_31_26 == 6'h05) && !id_inst[25];
    assign inst_pcaddu12i = (op_31_26 == 6'h07) && !id_inst[25];

    assign inst_jirl = (op_31_26 == 6'h13);
    assign inst_b    = (op_31_26 == 6'h14);
    assign inst_bl   = (op_31_26 == 6'h15);
    assign inst_beq  = (op_31_26 == 6'h16);
    assign inst_bne  = (op_31_26 == 6'h17);
    assign inst_blt  = (op_31_26 == 6'h18);
    assign inst_bge  = (op_31_26 == 6'h19);
    assign inst_bltu = (op_31_26 == 6'h1a);
    assign inst_bgeu = (op_31_26 == 6'h1b);

    assign cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    assign ine = !(inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                 | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w
                 | inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_slti
                 | inst_sltui | inst_andi | inst_ori | inst_xori | inst_lu12i_w
                 | inst_pcaddu12i | cond_br | inst_b | inst_bl | inst_jirl);

    always_comb begin
        alu_op = ALU_ADD;
        if (inst_sub_w)                    alu_op = ALU_SUB;
        else if (inst_slt | inst_slti)     alu_op = ALU_SLT;
        else if (inst_sltu | inst_sltui)   alu_op = ALU_SLTU;
        else if (inst_and | inst_andi)     alu_op = ALU_AND;
        else if (inst_nor)                 alu_op = ALU_NOR;
        else if (inst_or | inst_ori)       alu_op = ALU_OR;
        else if (inst_xor | inst_xori)     alu_op = ALU_XOR;
        else if (inst_sll_w | inst_slli_w) alu_op = ALU_SLL;
        else if (inst_srl_w | inst_srli_w) alu_op = ALU_SRL;
        else if (inst_sra_w | inst_srai_w) alu_op = ALU_SRA;
        else if (inst_lu12i_w)             alu_op = ALU_LUI;
    end

    always_comb begin
        br_kind = BR_NONE;
        if (inst_beq)       br_kind = BR_BEQ;
        else if (inst_bne)  br_kind = BR_BNE;
        else if (inst_blt)  br_kind = BR_BLT;
        else if (inst_bge)  br_kind = BR_BGE;
        else if (inst_bltu) br_kind = BR_BLTU;
        else if (inst_bgeu) br_kind = BR_BGEU;
        else if (inst_b)    br_kind = BR_B;
        else if (inst_bl)   br_kind = BR_BL;
        else if (inst_jirl) br_kind = BR_JIRL;
    end

    logic need_4, need_si20, need_ui5, need_si12, need_ui12;
    assign need_4    = inst_bl | inst_jirl;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_slti | inst_sltui;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;

    // link value is pc + 4
    assign imm = {`ID_XLEN{need_4}}    & {{(`ID_XLEN-3){1'b0}}, 3'd4}
               | {`ID_XLEN{need_si20}} & {i20, 12'b0}
               | {`ID_XLEN{need_ui5}}  & {{(`ID_XLEN-5){1'b0}}, i12[4:0]}
               | {`ID_XLEN{need_si12}} & {{(`ID_XLEN-12){i12[11]}}, i12}
               | {`ID_XLEN{need_ui12}} & {{(`ID_XLEN-12){1'b0}}, i12};

    assign br_offs = (inst_b | inst_bl) ? {{(`ID_XLEN-28){i26[25]}}, i26, 2'b0}
                                        : {{(`ID_XLEN-18){i16[15]}}, i16, 2'b0};

    // compare branches read rd as second source
    assign rkd  = cond_br ? rd : rk;
    assign dest = inst_bl ? `ID_REG_ADDR_W'(1) : rd;

    assign src1_is_pc    = inst_bl | inst_jirl | inst_pcaddu12i;
    assign src2_is_imm   = need_4 | need_si20 | need_ui5 | need_si12 | need_ui12;
    assign src2_is_shamt = inst_sll_w | inst_srl_w | inst_sra_w;
    assign gr_we         = !ine && !cond_br && !inst_b;

    ine_has_no_effect: assert final (!ine || (!gr_we && br_kind == BR_NONE));

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module reg_file (
    input  wire                      clk,
    input  wire [`ID_REG_ADDR_W-1:0] raddr1,
    input  wire [`ID_REG_ADDR_W-1:0] raddr2,
    output logic [`ID_XLEN-1:0]      rdata1,
    output logic [`ID_XLEN-1:0]      rdata2,
    input  wire                      we,
    input  wire [`ID_REG_ADDR_W-1:0] waddr,
    input  wire [`ID_XLEN-1:0]       wdata
);

    logic [`ID_XLEN-1:0] regs [`ID_REG_COUNT];
    logic                wr_live;

    // r0 is never stored
    assign wr_live = we && (waddr != '0);

    always_ff @(posedge clk) begin
        if (wr_live) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write shows through to the readers
    always_comb begin
        if (raddr1 == '0)
            rdata1 = '0;
        else if (wr_live && raddr1 == waddr)
            rdata1 = wdata;
        else
            rdata1 = regs[raddr1];
    end

    always_comb begin
        if (raddr2 == '0)
            rdata2 = '0;
        else if (wr_live && raddr2 == waddr)
            rdata2 = wdata;
        else
            rdata2 = regs[raddr2];
    end

    waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr));

endmodule

`default_nettype wire

// File: hdl/operand_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module operand_branch_unit (
    input  wire                   id_valid,
    input  wire                   exe_allowin,
    input  wire [`ID_XLEN-1:0]    id_pc,
    input  wire [`ID_XLEN-1:0]    rj_value,
    input  wire [`ID_XLEN-1:0]    rkd_value,
    input  wire [`ID_XLEN-1:0]    imm,
    input  wire [`ID_XLEN-1:0]    br_offs,
    input  id_pkg::br_kind_e      br_kind,
    input  wire                   src1_is_pc,
    input  wire                   src2_is_imm,
    input  wire                   src2_is_shamt,
    output logic [`ID_XLEN-1:0]   alu_src1,
    output logic [`ID_XLEN-1:0]   alu_src2,
    output logic                  br_taken,
    output logic                  br_cancel,
    output logic [`ID_XLEN-1:0]   br_target
);

    import id_pkg::*;

    logic [`ID_XLEN:0] diff;
    logic              rj_eq;
    logic              rj_lt;
    logic              rj_ltu;
    logic              cond;

    assign alu_src1 = src1_is_pc ? id_pc : rj_value;
    assign alu_src2 = src2_is_imm   ? imm :
                      src2_is_shamt ? {{(`ID_XLEN-5){1'b0}}, rkd_value[4:0]} :
                                      rkd_value;

    // rj - rkd with carry out, no borrow means rj >= rkd unsigned
    assign diff   = {1'b0, rj_value} + {1'b0, ~rkd_value} + {{`ID_XLEN{1'b0}}, 1'b1};
    assign rj_eq  = (rj_value == rkd_value);
    assign rj_ltu = !diff[`ID_XLEN];
    assign rj_lt  = (rj_value[`ID_XLEN-1] & ~rkd_value[`ID_XLEN-1])
                  | (~(rj_value[`ID_XLEN-1] ^ rkd_value[`ID_XLEN-1]) & diff[`ID_XLEN-1]);

    always_comb begin
        case (br_kind)
            BR_BEQ:                cond = rj_eq;
            BR_BNE:                cond = !rj_eq;
            BR_BLT:                cond = rj_lt;
            BR_BGE:                cond = !rj_lt;
            BR_BLTU:               cond = rj_ltu;
            BR_BGEU:               cond = !rj_ltu;
            BR_B, BR_BL, BR_JIRL:  cond = 1'b1;
            default:               cond = 1'b0;
        endcase
    end

    assign br_taken  = id_valid && cond;
    // only redirect once the branch actually moves on
    assign br_cancel = br_taken && exe_allowin;
    assign br_target = (br_kind == BR_JIRL) ? rj_value + br_offs : id_pc + br_offs;

    cancel_needs_item: assert final (!br_cancel || id_valid);

endmodule

`default_nettype wire

// File: hdl/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module id_stage (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire                       if_valid,
    input  wire [`ID_XLEN-1:0]        if_pc,
    input  wire [`ID_INST_W-1:0]      if_inst,
    output logic                      id_allowin,
    input  wire                       exe_allowin,
    output logic                      exe_valid,
    output logic [`ID_XLEN-1:0]       exe_pc,
    output id_pkg::alu_op_e           alu_op,
    output logic [`ID_XLEN-1:0]       alu_src1,
    output logic [`ID_XLEN-1:0]       alu_src2,
    output logic [`ID_XLEN-1:0]       rkd_value,
    output logic [`ID_REG_ADDR_W-1:0] dest,
    output logic                      gr_we,
    output logic                      ine,
    output logic                      br_taken,
    output logic                      br_cancel,
    output logic [`ID_XLEN-1:0]       br_target,
    input  wire                       wb_we,
    input  wire [`ID_REG_ADDR_W-1:0]  wb_addr,
    input  wire [`ID_XLEN-1:0]        wb_data
);

    import id_pkg::*;

    logic                      id_valid;
    logic [`ID_INST_W-1:0]     id_inst;
    logic [`ID_REG_ADDR_W-1:0] rj;
    logic [`ID_REG_ADDR_W-1:0] rkd;
    logic [`ID_XLEN-1:0]       rj_value;
    logic [`ID_XLEN-1:0]       imm;
    logic [`ID_XLEN-1:0]       br_offs;
    br_kind_e                  br_kind;
    logic                      src1_is_pc;
    logic                      src2_is_imm;
    logic                      src2_is_shamt;

    // no interlock, so the item is always ready to go
    assign id_allowin = !id_valid || exe_allowin;
    assign exe_valid  = id_valid;

    fetch_latch u_latch (
        .clk        (clk),
        .resetn     (resetn),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .if_inst    (if_inst),
        .id_allowin (id_allowin),
        .br_cancel  (br_cancel),
        .id_valid   (id_valid),
        .id_pc      (exe_pc),
        .id_inst    (id_inst)
    );

    inst_decoder u_dec (
        .id_inst       (id_inst),
        .rj            (rj),
        .rkd           (rkd),
        .dest          (dest),
        .alu_op        (alu_op),
        .br_kind       (br_kind),
        .imm           (imm),
        .br_offs       (br_offs),
        .src1_is_pc    (src1_is_pc),
        .src2_is_imm   (src2_is_imm),
        .src2_is_shamt (src2_is_shamt),
        .gr_we         (gr_we),
        .ine           (ine)
    );

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (rkd),
        .rdata1 (rj_value),
        .rdata2 (rkd_value),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    operand_branch_unit u_obu (
        .id_valid      (id_valid),
        .exe_allowin   (exe_allowin),
        .id_pc         (exe_pc),
        .rj_value      (rj_value),
        .rkd_value     (rkd_value),
        .imm           (imm),
        .br_offs       (br_offs),
        .br_kind       (br_kind),
        .src1_is_pc    (src1_is_pc),
        .src2_is_imm   (src2_is_imm),
        .src2_is_shamt (src2_is_shamt),
        .alu_src1      (alu_src1),
        .alu_src2      (alu_src2),
        .br_taken      (br_taken),
        .br_cancel     (br_cancel),
        .br_target     (br_target)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic resetn
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/id_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module id_checker (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      exe_valid,
    input  wire                      exe_allowin,
    input  wire [`ID_XLEN-1:0]       exe_pc,
    input  wire [3:0]                alu_op,
    input  wire [`ID_XLEN-1:0]       alu_src1,
    input  wire [`ID_XLEN-1:0]       alu_src2,
    input  wire [`ID_XLEN-1:0]       rkd_value,
    input  wire [`ID_REG_ADDR_W-1:0] dest,
    input  wire                      gr_we,
    input  wire                      ine,
    input  wire                      br_taken,
    input  wire                      br_cancel,
    input  wire [`ID_XLEN-1:0]       br_target,
    output int                       checked,
    output int                       errors
);

    typedef struct packed {
        logic [`ID_XLEN-1:0]       pc;
        logic [3:0]                op;
        logic [`ID_XLEN-1:0]       src1;
        logic [`ID_XLEN-1:0]       src2;
        logic [`ID_XLEN-1:0]       rkd;
        logic [`ID_REG_ADDR_W-1:0] dest;
        logic                      we;
        logic                      ine;
        logic                      tk;
        logic                      tchk;
        logic [`ID_XLEN-1:0]       tgt;
    } exp_t;

    exp_t exp_q[$];
    int   n_checked = 0;
    int   n_errors = 0;

    assign checked = n_checked;
    assign errors  = n_errors;

    task automatic expect_item(
        input logic [`ID_XLEN-1:0]       pc,
        input logic [3:0]                op,
        input logic [`ID_XLEN-1:0]       src1,
        input logic [`ID_XLEN-1:0]       src2,
        input logic [`ID_XLEN-1:0]       rkd,
        input logic [`ID_REG_ADDR_W-1:0] dst,
        input logic                      we,
        input logic                      inv,
        input logic                      tk,
        input logic                      tchk,
        input logic [`ID_XLEN-1:0]       tgt
    );
        exp_q.push_back({pc, op, src1, src2, rkd, dst, we, inv, tk, tchk, tgt});
    endtask

    function automatic bit field_ok(input string name, input logic [31:0] got,
                                    input logic [31:0] exp, input int idx);
        if (got !== exp) begin
            $display("[FAIL] item %0d %s: got %h expected %h", idx, name, got, exp);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    always @(posedge clk) begin
        exp_t e;
        bit   ok;
        if (resetn) begin
            if (br_cancel && !exe_allowin) begin
                $display("br_cancel was high while execute was stalled");
                n_errors++;
            end
            if (exe_valid && exe_allowin) begin
                if (exp_q.size() == 0) begin
                    $display("item at pc %h left the stage with no record expected", exe_pc);
                    n_errors++;
                end else begin
                    e = exp_q.pop_front();
                    ok = 1'b1;
                    ok &= field_ok("exe_pc", exe_pc, e.pc, n_checked);
                    ok &= field_ok("alu_op", 32'(alu_op), 32'(e.op), n_checked);
                    ok &= field_ok("alu_src1", alu_src1, e.src1, n_checked);
                    ok &= field_ok("alu_src2", alu_src2, e.src2, n_checked);
                    ok &= field_ok("rkd_value", rkd_value, e.rkd, n_checked);
                    ok &= field_ok("dest", 32'(dest), 32'(e.dest), n_checked);
                    ok &= field_ok("gr_we", 32'(gr_we), 32'(e.we), n_checked);
                    ok &= field_ok("ine", 32'(ine), 32'(e.ine), n_checked);
                    ok &= field_ok("br_taken", 32'(br_taken), 32'(e.tk), n_checked);
                    // leaving edge, so cancel follows taken
                    ok &= field_ok("br_cancel", 32'(br_cancel), 32'(e.tk), n_checked);
                    if (e.tchk) begin
                        ok &= field_ok("br_target", br_target, e.tgt, n_checked);
                    end
                    if (ok) begin
                        $display("[PASS] item %0d pc %h", n_checked, e.pc);
                    end else begin
                        n_errors++;
                    end
                    n_checked++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_settings.svh"

module tb_id_stage;

    logic                      clk;
    logic                      resetn;
    logic                      if_valid;
    logic [`ID_XLEN-1:0]       if_pc;
    logic [`ID_INST_W-1:0]     if_inst;
    logic                      id_allowin;
    logic                      exe_allowin;
    logic                      exe_valid;
    logic [`ID_XLEN-1:0]       exe_pc;
    logic [3:0]                alu_op;
    logic [`ID_XLEN-1:0]       alu_src1;
    logic [`ID_XLEN-1:0]       alu_src2;
    logic [`ID_XLEN-1:0]       rkd_value;
    logic [`ID_REG_ADDR_W-1:0] dest;
    logic                      gr_we;
    logic                      ine;
    logic                      br_taken;
    logic                      br_cancel;
    logic [`ID_XLEN-1:0]       br_target;
    logic                      wb_we;
    logic [`ID_REG_ADDR_W-1:0] wb_addr;
    logic [`ID_XLEN-1:0]       wb_data;
    int                        checked;
    int                        errors;

    integer                    seed = 46;
    int                        limit = 1000000;
    int                        cycles = 0;
    int                        local_errors = 0;
    int                        n_expected = 0;
    bit                        bp_on = 1'b0;
    logic [`ID_REG_ADDR_W-1:0] w_addr[$];
    logic [`ID_XLEN-1:0]       w_data[$];
    logic [`ID_XLEN-1:0]       i_pc[$];
    logic [`ID_INST_W-1:0]     i_inst[$];

    tb_clock u_clk (.clk(clk), .resetn(resetn));

    id_stage dut (.*);

    id_checker chk (.*);

    task automatic load_records();
        int fd;
        int n;
        string line;
        logic [31:0] a, d, pc, inst, op, s1, s2, rkd, dst, we, inv, tk, tchk, tgt, wp;
        fd = $fopen("bench/id_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/id_testdata.txt");
            local_errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) == "W") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
                    if (n != 2 || a >= `ID_REG_COUNT) begin
                        $display("bad register record: %s", line);
                        local_errors++;
                    end else begin
                        w_addr.push_back(a[`ID_REG_ADDR_W-1:0]);
                        w_data.push_back(d);
                    end
                end else if (n > 1 && line.getc(0) == "I") begin
                    n = $sscanf(line.substr(1, line.len() - 1),
                                "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                pc, inst, op, s1, s2, rkd, dst, we, inv, tk, tchk, tgt, wp);
                    if (n != 13) begin
                        $display("bad instruction record: %s", line);
                        local_errors++;
                    end else begin
                        i_pc.push_back(pc);
                        i_inst.push_back(inst);
                        // wrong-path items never reach execute
                        if (wp[0] == 1'b0) begin
                            chk.expect_item(pc, op[3:0], s1, s2, rkd, dst[4:0], we[0],
                                            inv[0], tk[0], tchk[0], tgt);
                            n_expected++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_reset_state();
        if (exe_valid !== 1'b0 || br_taken !== 1'b0 || br_cancel !== 1'b0
            || id_allowin !== 1'b1) begin
            $display("[FAIL] reset state exe_valid %h br_taken %h br_cancel %h id_allowin %h",
                     exe_valid, br_taken, br_cancel, id_allowin);
            local_errors++;
        end else begin
            $display("[PASS] reset state");
        end
    endtask

    task automatic drive_writes();
        for (int i = 0; i < w_addr.size(); i++) begin
            wb_we   = 1'b1;
            wb_addr = w_addr[i];
            wb_data = w_data[i];
            @(posedge clk);
            #1;
        end
        wb_we = 1'b0;
    endtask

    // back-to-back drive puts a wrong-path item on the port when its branch leaves
    task automatic drive_instructions();
        for (int i = 0; i < i_pc.size(); i++) begin
            if_valid = 1'b1;
            if_pc    = i_pc[i];
            if_inst  = i_inst[i];
            @(posedge clk);
            while (!id_allowin) @(posedge clk);
            #1;
        end
        if_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        #1;
        if (bp_on) begin
            exe_allowin = (($random(seed) & 3) != 0);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        if_valid    = 1'b0;
        if_pc       = '0;
        if_inst     = '0;
        exe_allowin = 1'b0;
        wb_we       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        load_records();
        limit = (w_addr.size() + i_pc.size()) * 8 + 100;
        wait (resetn === 1'b1);
        @(posedge clk);
        check_reset_state();
        bp_on = 1'b1;
        #1;
        drive_writes();
        drive_instructions();
        wait (checked == n_expected);
        repeat (10) @(posedge clk);
        $display("summary: %0d of %0d items checked, %0d errors",
                 checked, n_expected, errors + local_errors);
        if (errors + local_errors == 0 && checked == n_expected) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/id_pkg.sv
hdl/fetch_latch.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/operand_branch_unit.sv
hdl/id_stage.sv
bench/tb_clock.sv
bench/id_checker.sv
bench/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard hdl/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/id_testdata.txt
# W reg value
# I pc inst alu_op src1 src2 rkd dest gr_we ine br_taken check_target br_target wrong_path
W 00 deadbeef
W 01 00000005
W 02 00000003
W 03 fffffff0
W 04 00000024
W 05 80000000
W 06 00001000
I 1c000000 00100827 0 00000005 00000003 00000003 07 1 0 0 0 00000000 0
I 1c000004 00110468 1 fffffff0 00000005 00000005 08 1 0 0 0 00000000 0
I 1c000008 00120469 2 fffffff0 00000005 00000005 09 1 0 0 0 00000000 0
I 1c00000c 00128c2a 3 00000005 fffffff0 fffffff0 0a 1 0 0 0 00000000 0
I 1c000010 0014082b 5 00000005 00000003 00000003 0b 1 0 0 0 00000000 0
I 1c000014 0014882c 4 00000005 00000003 00000003 0c 1 0 0 0 00000000 0
I 1c000018 0015082d 6 00000005 00000003 00000003 0d 1 0 0 0 00000000 0
I 1c00001c 0015882e 7 00000005 00000003 00000003 0e 1 0 0 0 00000000 0
I 1c000020 0017102f 8 00000005 00000004 00000024 0f 1 0 0 0 00000000 0
I 1c000024 001810b0 a 80000000 00000004 00000024 10 1 0 0 0 00000000 0
I 1c000028 00448cb1 9 80000000 00000003 fffffff0 11 1 0 0 0 00000000 0
I 1c00002c 00408832 8 00000005 00000002 00000003 12 1 0 0 0 00000000 0
I 1c000030 02bf8033 0 00000005 ffffffe0 00000000 13 1 0 0 0 00000000 0
I 1c000034 02001474 2 fffffff0 00000005 80000000 14 1 0 0 0 00000000 0
I 1c000038 02600035 3 00000005 fffff800 00000000 15 1 0 0 0 00000000 0
I 1c00003c 037c0476 4 fffffff0 00000f01 00000005 16 1 0 0 0 00000000 0
I 1c000040 03a00817 6 00000000 00000802 00000003 17 1 0 0 0 00000000 0
I 1c000044 03c01858 7 00000003 00000006 00001000 18 1 0 0 0 00000000 0
I 1c000048 142400b9 b 80000000 12005000 00000000 19 1 0 0 0 00000000 0
I 1c00004c 1c00003a 0 1c00004c 00001000 00000000 1a 1 0 0 0 00000000 0
I 1c000050 58001022 0 00000005 00000003 00000003 02 0 0 0 1 1c000060 0
I 1c000054 5c001022 0 00000005 00000003 00000003 02 0 0 1 1 1c000064 0
I 1c000058 00100827 0 00000000 00000000 00000000 00 0 0 0 0 00000000 1
I 1c00005c 63fff861 0 fffffff0 00000005 00000005 01 0 0 1 1 1c000054 0
I 1c000060 00100827 0 00000000 00000000 00000000 00 0 0 0 0 00000000 1
I 1c000064 64001061 0 fffffff0 00000005 00000005 01 0 0 0 1 1c000074 0
I 1c000068 68001061 0 fffffff0 00000005 00000005 01 0 0 0 1 1c000078 0
I 1c00006c 6c001061 0 fffffff0 00000005 00000005 01 0 0 1 1 1c00007c 0
I 1c000070 00100827 0 00000000 00000000 00000000 00 0 0 0 0 00000000 1
I 1c000074 50040000 0 00000000 00000000 00000000 00 0 0 1 1 1c000474 0
I 1c000078 00100827 0 00000000 00000000 00000000 00 0 0 0 0 00000000 1
I 1c00007c 54010000 0 1c00007c 00000004 00000000 01 1 0 1 1 1c00017c 0
I 1c000080 00100827 0 00000000 00000000 00000000 00 0 0 0 0 00000000 1
I 1c000084 4c0008c1 0 1c000084 00000004 00000003 01 1 0 1 1 00001008 0
I 1c000088 00100827 0 00000000 00000000 00000000 00 0 0 0 0 00000000 1
I 1c00008c fc000000 0 00000000 00000000 00000000 00 0 1 0 0 00000000 0
I 1c000090 0010001b 0 00000000 00000000 00000000 1b 1 0 0 0 00000000 0
